//--- compile.f
src/csr_pkg.sv
src/csr_access_decode.sv
src/machine_csr_regs.sv
src/perf_counter_bank.sv
src/csr_read_assemble.sv
src/cs_registers.sv
testbench/cs_registers_sva.sv
testbench/tb_cs_registers.sv

//--- run.sh
#!/bin/sh
# build and run the cs_registers testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cs_registers -f compile.f

# output goes to the terminal, the pass line decides the status
./obj_dir/Vtb_cs_registers | tee /dev/stderr | grep "No errors" > /dev/null
echo "simulation passed"

//--- src/cs_registers.sv
`timescale 1ns/1ps

module cs_registers (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [3:0]          core_id_i,
  input  logic [5:0]          cluster_id_i,
  // csr port
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  input  csr_pkg::csr_op_t    csr_op_i,
  output csr_pkg::csr_data_t  csr_rdata_o,
  // interrupts and exceptions
  output logic                irq_enable_o,
  output csr_pkg::csr_data_t  mepc_o,
  input  csr_pkg::csr_data_t  pc_if_i,
  input  csr_pkg::csr_data_t  pc_id_i,
  input  csr_pkg::csr_data_t  pc_ex_i,
  input  csr_pkg::csr_data_t  branch_target_i,
  input  logic                data_load_event_ex_i,
  input  logic                exc_save_if_i,
  input  logic                exc_save_id_i,
  input  logic                exc_save_takenbranch_i,
  input  logic                exc_restore_i,
  input  csr_pkg::exc_cause_t exc_cause_i,
  input  logic                save_exc_cause_i,
  // perf events
  input  logic                id_valid_i,
  input  logic                is_compressed_i,
  input  logic                is_decoding_i,
  input  logic                imiss_i,
  input  logic                pc_set_i,
  input  logic                jump_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  input  logic                ld_stall_i,
  input  logic                jr_stall_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i
);

  logic                sel_mstatus, sel_mepc, sel_mcause, sel_mestatus;
  logic                sel_pcer, sel_pcmr, sel_pccr, sel_pccr_all;
  logic [4:0]          pccr_index;
  logic                csr_we;
  csr_pkg::csr_data_t  csr_wdata_mod, old_rdata, pccr_rdata;
  logic                mestatus_ie;
  csr_pkg::exc_cause_t mcause;
  csr_pkg::perf_evt_t  pcer;
  csr_pkg::perf_mode_t pcmr;

  csr_access_decode u_decode (
    .csr_access_i, .csr_addr_i, .csr_op_i, .csr_wdata_i,
    .old_rdata_i(old_rdata),
    .sel_mstatus_o(sel_mstatus), .sel_mepc_o(sel_mepc), .sel_mcause_o(sel_mcause),
    .sel_mestatus_o(sel_mestatus), .sel_pcer_o(sel_pcer), .sel_pcmr_o(sel_pcmr),
    .sel_pccr_o(sel_pccr), .sel_pccr_all_o(sel_pccr_all), .pccr_index_o(pccr_index),
    .csr_we_o(csr_we), .csr_wdata_mod_o(csr_wdata_mod)
  );

  machine_csr_regs u_mregs (
    .clk, .rst_n,
    .sel_mstatus_i(sel_mstatus), .sel_mepc_i(sel_mepc), .sel_mcause_i(sel_mcause),
    .sel_mestatus_i(sel_mestatus), .csr_we_i(csr_we), .csr_wdata_mod_i(csr_wdata_mod),
    .pc_if_i, .pc_id_i, .pc_ex_i, .branch_target_i,
    .exc_save_if_i, .exc_save_id_i, .exc_save_takenbranch_i, .data_load_event_ex_i,
    .exc_restore_i, .save_exc_cause_i, .exc_cause_i,
    .mstatus_ie_o(irq_enable_o), .mestatus_ie_o(mestatus_ie),
    .mepc_o, .mcause_o(mcause)
  );

  perf_counter_bank u_perf (
    .clk, .rst_n,
    .sel_pcer_i(sel_pcer), .sel_pcmr_i(sel_pcmr), .sel_pccr_i(sel_pccr),
    .sel_pccr_all_i(sel_pccr_all), .pccr_index_i(pccr_index),
    .csr_we_i(csr_we), .csr_wdata_mod_i(csr_wdata_mod),
    .id_valid_i, .is_compressed_i, .is_decoding_i, .imiss_i, .pc_set_i,
    .jump_i, .branch_i, .branch_taken_i, .ld_stall_i, .jr_stall_i,
    .mem_load_i, .mem_store_i,
    .pcer_o(pcer), .pcmr_o(pcmr), .pccr_rdata_o(pccr_rdata)
  );

  csr_read_assemble u_read (
    .csr_addr_i, .core_id_i, .cluster_id_i,
    .mstatus_ie_i(irq_enable_o), .mestatus_ie_i(mestatus_ie),
    .mepc_i(mepc_o), .mcause_i(mcause), .pcer_i(pcer), .pcmr_i(pcmr),
    .pccr_rdata_i(pccr_rdata),
    .csr_rdata_o, .old_rdata_o(old_rdata)
  );

endmodule

//--- src/csr_access_decode.sv
`timescale 1ns/1ps

module csr_access_decode (
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_op_t    csr_op_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  input  csr_pkg::csr_data_t  old_rdata_i,   // same word the read port shows
  output logic                sel_mstatus_o,
  output logic                sel_mepc_o,
  output logic                sel_mcause_o,
  output logic                sel_mestatus_o,
  output logic                sel_pcer_o,
  output logic                sel_pcmr_o,
  output logic                sel_pccr_o,
  output logic                sel_pccr_all_o,
  output logic [4:0]          pccr_index_o,
  output logic                csr_we_o,
  output csr_pkg::csr_data_t  csr_wdata_mod_o
);

  logic in_pccr_window;  // 0x780..0x79F

  ////////////////////////////////////////////////////
  // register selects
  ////////////////////////////////////////////////////

  assign in_pccr_window = (csr_addr_i[11:5] == csr_pkg::PCCR_BASE_HI);

  // selects only fire on a real access
  assign sel_mstatus_o  = csr_access_i && (csr_addr_i == csr_pkg::ADDR_MSTATUS);
  assign sel_mepc_o     = csr_access_i && (csr_addr_i == csr_pkg::ADDR_MEPC);
  assign sel_mcause_o   = csr_access_i && (csr_addr_i == csr_pkg::ADDR_MCAUSE);
  assign sel_mestatus_o = csr_access_i && (csr_addr_i == csr_pkg::ADDR_MESTATUS);
  assign sel_pcer_o     = csr_access_i && (csr_addr_i == csr_pkg::ADDR_PCER);
  assign sel_pcmr_o     = csr_access_i && (csr_addr_i == csr_pkg::ADDR_PCMR);
  assign sel_pccr_o     = csr_access_i && in_pccr_window;  // 0x79F falls in here too
  assign sel_pccr_all_o = csr_access_i && (csr_addr_i == csr_pkg::ADDR_PCCR_ALL);

  assign pccr_index_o   = csr_addr_i[4:0];  // low bits pick the counter

  ////////////////////////////////////////////////////
  // op rule, one word for every register
  ////////////////////////////////////////////////////

  assign csr_we_o = (csr_op_i != csr_pkg::CSR_OP_NONE);

  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_OP_SET:   csr_wdata_mod_o = old_rdata_i | csr_wdata_i;
      csr_pkg::CSR_OP_CLEAR: csr_wdata_mod_o = old_rdata_i & ~csr_wdata_i;
      default:               csr_wdata_mod_o = csr_wdata_i;  // write, none
    endcase
  end

endmodule

//--- src/csr_pkg.sv
package csr_pkg;

  ////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////

  localparam int N_PERF_COUNTERS = 11;

  typedef logic [11:0]                csr_addr_t;   // csr address
  typedef logic [31:0]                csr_data_t;   // data word, also pc
  typedef logic [1:0]                 csr_op_t;     // access operation
  typedef logic [5:0]                 exc_cause_t;  // bit 5 marks an interrupt
  typedef logic [N_PERF_COUNTERS-1:0] perf_evt_t;   // one bit per counter
  typedef logic [1:0]                 perf_mode_t;  // pcmr, [0] enable [1] saturate

  // access ops
  localparam csr_op_t CSR_OP_NONE  = 2'd0;
  localparam csr_op_t CSR_OP_WRITE = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;

  // machine mode map
  localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
  localparam csr_addr_t ADDR_MEPC     = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
  localparam csr_addr_t ADDR_MESTATUS = 12'h7C0;
  localparam csr_addr_t ADDR_MCPUID   = 12'hF00;
  localparam csr_addr_t ADDR_MIMPID   = 12'hF01;
  localparam csr_addr_t ADDR_MHARTID  = 12'hF10;

  // perf counter map
  localparam csr_addr_t  ADDR_PCER     = 12'h7A0;
  localparam csr_addr_t  ADDR_PCMR     = 12'h7A1;
  localparam csr_addr_t  ADDR_PCCR_ALL = 12'h79F;
  localparam logic [6:0] PCCR_BASE_HI  = 7'b0111100;  // window 0x780..0x79F

  localparam csr_data_t  MCPUID_VALUE  = 32'h0080_1100;  // rv32im plus x
  localparam csr_data_t  MIMPID_VALUE  = 32'h0000_8000;
  localparam perf_mode_t PCMR_RESET    = 2'b11;         // enabled, saturating

  // counter slots
  localparam int CNT_CYCLES       = 0;
  localparam int CNT_INSTR        = 1;
  localparam int CNT_LD_STALL     = 2;
  localparam int CNT_JR_STALL     = 3;
  localparam int CNT_IMISS        = 4;
  localparam int CNT_LOAD         = 5;
  localparam int CNT_STORE        = 6;
  localparam int CNT_JUMP         = 7;
  localparam int CNT_BRANCH       = 8;
  localparam int CNT_BRANCH_TAKEN = 9;
  localparam int CNT_COMPRESSED   = 10;

endpackage

//--- src/csr_read_assemble.sv
`timescale 1ns/1ps

module csr_read_assemble (
  input  csr_pkg::csr_addr_t   csr_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  input  logic                 mstatus_ie_i,
  input  logic                 mestatus_ie_i,
  input  csr_pkg::csr_data_t   mepc_i,
  input  csr_pkg::exc_cause_t  mcause_i,
  input  csr_pkg::perf_evt_t   pcer_i,
  input  csr_pkg::perf_mode_t  pcmr_i,
  input  csr_pkg::csr_data_t   pccr_rdata_i,
  output csr_pkg::csr_data_t   csr_rdata_o,
  output csr_pkg::csr_data_t   old_rdata_o
);

  csr_pkg::csr_data_t rdata;

  always_comb begin
    case (csr_addr_i)
      csr_pkg::ADDR_MSTATUS:  rdata = {29'b0, 2'b11, mstatus_ie_i};   // always m-mode
      csr_pkg::ADDR_MESTATUS: rdata = {29'b0, 2'b11, mestatus_ie_i};
      csr_pkg::ADDR_MEPC:     rdata = mepc_i;
      csr_pkg::ADDR_MCAUSE:   rdata = {mcause_i[5], 26'b0, mcause_i[4:0]};  // irq flag on top
      csr_pkg::ADDR_MCPUID:   rdata = csr_pkg::MCPUID_VALUE;
      csr_pkg::ADDR_MIMPID:   rdata = csr_pkg::MIMPID_VALUE;
      csr_pkg::ADDR_MHARTID:  rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      csr_pkg::ADDR_PCER:     rdata = {{(32 - csr_pkg::N_PERF_COUNTERS){1'b0}}, pcer_i};
      csr_pkg::ADDR_PCMR:     rdata = {30'b0, pcmr_i};
      default: begin
        // counter window, else unmapped reads 0
        if (csr_addr_i[11:5] == csr_pkg::PCCR_BASE_HI) rdata = pccr_rdata_i;
        else                                           rdata = '0;
      end
    endcase
  end

  assign csr_rdata_o = rdata;
  assign old_rdata_o = rdata;  // feeds set and clear

endmodule

//--- src/machine_csr_regs.sv
`timescale 1ns/1ps

module machine_csr_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sel_mstatus_i,
  input  logic                 sel_mepc_i,
  input  logic                 sel_mcause_i,
  input  logic                 sel_mestatus_i,
  input  logic                 csr_we_i,
  input  csr_pkg::csr_data_t   csr_wdata_mod_i,
  input  csr_pkg::csr_data_t   pc_if_i,
  input  csr_pkg::csr_data_t   pc_id_i,
  input  csr_pkg::csr_data_t   pc_ex_i,
  input  csr_pkg::csr_data_t   branch_target_i,
  input  logic                 exc_save_if_i,
  input  logic                 exc_save_id_i,
  input  logic                 exc_save_takenbranch_i,
  input  logic                 data_load_event_ex_i,
  input  logic                 exc_restore_i,
  input  logic                 save_exc_cause_i,
  input  csr_pkg::exc_cause_t  exc_cause_i,
  output logic                 mstatus_ie_o,
  output logic                 mestatus_ie_o,
  output csr_pkg::csr_data_t   mepc_o,
  output csr_pkg::exc_cause_t  mcause_o
);

  logic                mstatus_q, mstatus_n;
  logic                mestatus_q, mestatus_n;
  csr_pkg::csr_data_t  mepc_q, mepc_n;
  csr_pkg::exc_cause_t mcause_q, mcause_n;
  logic                exc_save;

  assign exc_save = exc_save_if_i | exc_save_id_i | exc_save_takenbranch_i;

  always_comb begin
    mstatus_n  = mstatus_q;
    mestatus_n = mestatus_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    // software writes first, lowest priority
    if (csr_we_i && sel_mstatus_i)  mstatus_n  = csr_wdata_mod_i[0];
    if (csr_we_i && sel_mestatus_i) mestatus_n = csr_wdata_mod_i[0];
    if (csr_we_i && sel_mepc_i)     mepc_n     = csr_wdata_mod_i;
    if (csr_we_i && sel_mcause_i) begin
      mcause_n = {csr_wdata_mod_i[31], csr_wdata_mod_i[4:0]};  // read layout
    end

    if (exc_save) begin
      mestatus_n = mstatus_q;  // stash ie
      mstatus_n  = 1'b0;       // irqs off in handler
      if (data_load_event_ex_i)        mepc_n = pc_ex_i;  // load fault in ex
      else if (exc_save_takenbranch_i) mepc_n = branch_target_i;
      else if (exc_save_if_i)          mepc_n = pc_if_i;
      else                             mepc_n = pc_id_i;
    end

    if (save_exc_cause_i) mcause_n  = exc_cause_i;
    if (exc_restore_i)    mstatus_n = mestatus_q;  // back from handler
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= 1'b0;
      mestatus_q <= 1'b0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mestatus_q <= mestatus_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign mstatus_ie_o  = mstatus_q;
  assign mestatus_ie_o = mestatus_q;
  assign mepc_o        = mepc_q;
  assign mcause_o      = mcause_q;

endmodule

//--- src/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sel_pcer_i,
  input  logic                sel_pcmr_i,
  input  logic                sel_pccr_i,
  input  logic                sel_pccr_all_i,
  input  logic [4:0]          pccr_index_i,
  input  logic                csr_we_i,
  input  csr_pkg::csr_data_t  csr_wdata_mod_i,
  input  logic                id_valid_i,       // id stage done
  input  logic                is_compressed_i,
  input  logic                is_decoding_i,
  input  logic                imiss_i,
  input  logic                pc_set_i,
  input  logic                jump_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  input  logic                ld_stall_i,
  input  logic                jr_stall_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i,
  output csr_pkg::perf_evt_t  pcer_o,
  output csr_pkg::perf_mode_t pcmr_o,
  output csr_pkg::csr_data_t  pccr_rdata_o      // counter at pccr_index_i
);

  localparam int N = csr_pkg::N_PERF_COUNTERS;

  logic                id_valid_q;
  csr_pkg::perf_evt_t  evt, inc, inc_q;
  csr_pkg::perf_evt_t  pcer_q;
  csr_pkg::perf_mode_t pcmr_q;
  csr_pkg::csr_data_t  cnt_q [N];
  csr_pkg::csr_data_t  cnt_n [N];

  ////////////////////////////////////////////////////
  // event lines
  ////////////////////////////////////////////////////

  assign evt[csr_pkg::CNT_CYCLES]       = 1'b1;
  assign evt[csr_pkg::CNT_INSTR]        = id_valid_i & is_decoding_i;
  assign evt[csr_pkg::CNT_LD_STALL]     = ld_stall_i & id_valid_q;   // load use hazard
  assign evt[csr_pkg::CNT_JR_STALL]     = jr_stall_i & id_valid_q;
  assign evt[csr_pkg::CNT_IMISS]        = imiss_i & ~pc_set_i;       // not jumps
  assign evt[csr_pkg::CNT_LOAD]         = mem_load_i;
  assign evt[csr_pkg::CNT_STORE]        = mem_store_i;
  assign evt[csr_pkg::CNT_JUMP]         = jump_i & id_valid_q;
  assign evt[csr_pkg::CNT_BRANCH]       = branch_i & id_valid_q;
  assign evt[csr_pkg::CNT_BRANCH_TAKEN] = branch_i & branch_taken_i & id_valid_q;
  assign evt[csr_pkg::CNT_COMPRESSED]   = id_valid_i & is_decoding_i & is_compressed_i;

  assign inc = evt & pcer_q & {N{pcmr_q[0]}};  // per-counter and global enable

  ////////////////////////////////////////////////////
  // counter next state
  ////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N; i++) begin
      cnt_n[i] = cnt_q[i];
      // saturate holds at all ones, else wraps
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) cnt_n[i] = cnt_q[i] + 32'd1;
      if (csr_we_i && sel_pccr_i && (sel_pccr_all_i || (pccr_index_i == i[4:0]))) begin
        cnt_n[i] = csr_wdata_mod_i;  // sw write beats the increment
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= csr_pkg::PCMR_RESET;
      for (int i = 0; i < N; i++) cnt_q[i] <= '0;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;  // one cycle to the counter
      if (csr_we_i && sel_pcer_i) pcer_q <= csr_wdata_mod_i[N-1:0];
      if (csr_we_i && sel_pcmr_i) pcmr_q <= csr_wdata_mod_i[1:0];
      for (int i = 0; i < N; i++) cnt_q[i] <= cnt_n[i];
    end
  end

  assign pcer_o       = pcer_q;
  assign pcmr_o       = pcmr_q;
  assign pccr_rdata_o = (pccr_index_i < 5'(N)) ? cnt_q[pccr_index_i[3:0]] : '0;  // 0x79F reads 0

endmodule

//--- testbench/cs_registers_sva.sv
`timescale 1ns/1ps

module cs_registers_sva (
  input logic               clk,
  input logic               rst_n,
  input csr_pkg::csr_addr_t csr_addr_i,
  input csr_pkg::csr_data_t csr_rdata_o,
  input logic               irq_enable_o,
  input logic               exc_save_if_i,
  input logic               exc_save_id_i,
  input logic               exc_save_takenbranch_i,
  input logic               data_load_event_ex_i,
  input logic               exc_restore_i
);

  logic any_save;
  logic mapped;  // any address with a read word

  assign any_save = exc_save_if_i | exc_save_id_i | exc_save_takenbranch_i;
  assign mapped   = (csr_addr_i == csr_pkg::ADDR_MSTATUS) ||
                    (csr_addr_i == csr_pkg::ADDR_MEPC) ||
                    (csr_addr_i == csr_pkg::ADDR_MCAUSE) ||
                    (csr_addr_i == csr_pkg::ADDR_MESTATUS) ||
                    (csr_addr_i == csr_pkg::ADDR_MCPUID) ||
                    (csr_addr_i == csr_pkg::ADDR_MIMPID) ||
                    (csr_addr_i == csr_pkg::ADDR_MHARTID) ||
                    (csr_addr_i == csr_pkg::ADDR_PCER) ||
                    (csr_addr_i == csr_pkg::ADDR_PCMR) ||
                    (csr_addr_i[11:5] == csr_pkg::PCCR_BASE_HI);

  a_save_sources: assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_save_takenbranch_i && data_load_event_ex_i))
    else $error("taken branch save and ex load event high together");

  a_save_irq_off: assert property (@(posedge clk) disable iff (!rst_n)
    (any_save && !exc_restore_i) |=> !irq_enable_o)
    else $error("irq_enable_o still high after an exception save");

  a_unmapped_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !mapped |-> (csr_rdata_o == '0))
    else $error("unmapped address %h read nonzero", csr_addr_i);

endmodule

bind cs_registers cs_registers_sva u_sva (
  .clk(clk),
  .rst_n(rst_n),
  .csr_addr_i(csr_addr_i),
  .csr_rdata_o(csr_rdata_o),
  .irq_enable_o(irq_enable_o),
  .exc_save_if_i(exc_save_if_i),
  .exc_save_id_i(exc_save_id_i),
  .exc_save_takenbranch_i(exc_save_takenbranch_i),
  .data_load_event_ex_i(data_load_event_ex_i),
  .exc_restore_i(exc_restore_i)
);

//--- testbench/tb_cs_registers.sv
`timescale 1ns/1ps

module tb_cs_registers;

  logic                clk, rst_n;
  logic [3:0]          core_id_i;
  logic [5:0]          cluster_id_i;
  logic                csr_access_i;
  csr_pkg::csr_addr_t  csr_addr_i;
  csr_pkg::csr_data_t  csr_wdata_i, csr_rdata_o, mepc_o;
  csr_pkg::csr_op_t    csr_op_i;
  logic                irq_enable_o;
  csr_pkg::csr_data_t  pc_if_i, pc_id_i, pc_ex_i, branch_target_i;
  logic                data_load_event_ex_i, exc_save_if_i, exc_save_id_i;
  logic                exc_save_takenbranch_i, exc_restore_i, save_exc_cause_i;
  csr_pkg::exc_cause_t exc_cause_i;
  logic                id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i;
  logic                jump_i, branch_i, branch_taken_i, ld_stall_i, jr_stall_i;
  logic                mem_load_i, mem_store_i;

  int                  n_checks, n_errors;
  logic                cmp_req;                   // compare at the next falling edge
  int                  cmp_src;                   // 0 read data, 1 mepc_o, 2 irq_enable_o
  string               cmp_name;
  csr_pkg::csr_data_t  cmp_exp, cmp_mask, cmp_act;

  cs_registers dut (.*);

  always #5 clk = ~clk;

  // expected value of a register after an access
  function automatic csr_pkg::csr_data_t csr_expect(csr_pkg::csr_op_t op,
      csr_pkg::csr_data_t old_val, csr_pkg::csr_data_t w);
    case (op)
      csr_pkg::CSR_OP_WRITE: return w;
      csr_pkg::CSR_OP_SET:   return old_val | w;
      csr_pkg::CSR_OP_CLEAR: return old_val & ~w;
      default:               return old_val;  // none leaves it alone
    endcase
  endfunction

  function automatic csr_pkg::csr_addr_t counter_addr(int idx);
    return {csr_pkg::PCCR_BASE_HI, 5'(idx)};
  endfunction

  ////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (cmp_req) begin
      case (cmp_src)
        1:       cmp_act = mepc_o;
        2:       cmp_act = {31'b0, irq_enable_o};
        default: cmp_act = csr_rdata_o;  // combinational read
      endcase
      n_checks++;
      if ((cmp_act & cmp_mask) !== (cmp_exp & cmp_mask)) begin
        n_errors++;
        $display("Mismatch in %s: expected %h, actual %h", cmp_name,
                 cmp_exp & cmp_mask, cmp_act & cmp_mask);
      end
    end
  end

  ////////////////////////////////////////////////////
  // stimulus tasks, all start and end 1 ns past a rising edge
  ////////////////////////////////////////////////////

  task automatic csr_cycle(csr_pkg::csr_op_t op, csr_pkg::csr_addr_t addr,
      csr_pkg::csr_data_t w);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = w;
    @(posedge clk);
    #1;
    csr_access_i = 1'b0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
  endtask

  task automatic expect_read(string name, csr_pkg::csr_addr_t addr,
      csr_pkg::csr_data_t exp, csr_pkg::csr_data_t mask);
    csr_addr_i = addr;
    cmp_src    = 0;
    cmp_name   = name;
    cmp_exp    = exp;
    cmp_mask   = mask;
    cmp_req    = 1'b1;
    @(posedge clk);
    #1;
    cmp_req = 1'b0;
  endtask

  task automatic expect_signal(string name, int src, csr_pkg::csr_data_t exp);
    cmp_src  = src;
    cmp_name = name;
    cmp_exp  = exp;
    cmp_mask = '1;
    cmp_req  = 1'b1;
    @(posedge clk);
    #1;
    cmp_req = 1'b0;
  endtask

  task automatic wait_irq(logic level, string name);
    int cyc;
    cyc = 0;
    while (irq_enable_o !== level && cyc < 20) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (irq_enable_o !== level) begin
      n_errors++;
      $display("%s: irq_enable_o did not reach %0b within 20 cycles", name, level);
    end
  endtask

  // kinds 0 load in ex, 1 taken branch, 2 if, 3 id, 4 restore
  task automatic exc_pulse(int kind);
    exc_save_id_i          = (kind == 0) || (kind == 3);
    data_load_event_ex_i   = (kind == 0);
    exc_save_takenbranch_i = (kind == 1);
    exc_save_if_i          = (kind == 2);
    exc_restore_i          = (kind == 4);
    @(posedge clk);
    #1;
    {exc_save_id_i, data_load_event_ex_i, exc_save_takenbranch_i, exc_save_if_i,
     exc_restore_i} = '0;
  endtask

  task automatic count_events(string name, int idx);
    csr_pkg::csr_data_t r;
    int                 n;
    r = $urandom;
    n = 1 + int'(r[3:0]);
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h0);
    csr_cycle(csr_pkg::CSR_OP_WRITE, counter_addr(idx), 32'h0);
    id_valid_i = 1'b1;  // delayed copy gates the branch events
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'd1 << idx);
    for (int i = 0; i < n; i++) begin
      mem_load_i     = (idx == csr_pkg::CNT_LOAD);
      mem_store_i    = (idx == csr_pkg::CNT_STORE);
      branch_i       = (idx == csr_pkg::CNT_BRANCH_TAKEN);
      branch_taken_i = (idx == csr_pkg::CNT_BRANCH_TAKEN);
      @(posedge clk);
      #1;
      {mem_load_i, mem_store_i, branch_i, branch_taken_i} = '0;
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);  // event, increment, count
    #1;
    expect_read(name, counter_addr(idx), 32'(n), '1);
    id_valid_i = 1'b0;
  endtask

  // counter 0 from three below the top, ten cycles of counting
  task automatic run_near_top(csr_pkg::csr_data_t mode);
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h0);
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCMR, mode);
    csr_cycle(csr_pkg::CSR_OP_WRITE, counter_addr(0), 32'hFFFF_FFFD);
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h1);
    repeat (10) @(posedge clk);
    #1;
  endtask

  task automatic report_test(string name, int errs_before);
    $display("test %-11s done, %0d errors", name, n_errors - errs_before);
  endtask

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    csr_pkg::csr_data_t model [4];
    csr_pkg::csr_data_t keep [4];
    csr_pkg::csr_data_t fixed [4];
    csr_pkg::csr_addr_t addrs [4];
    csr_pkg::csr_data_t r, w;
    csr_pkg::csr_op_t   op;
    int                 errs;
    void'($urandom(32'h392b));
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmp_req  = 1'b0;
    cmp_src  = 0;
    n_checks = 0;
    n_errors = 0;
    {core_id_i, cluster_id_i, csr_access_i, csr_addr_i, csr_wdata_i, csr_op_i} = '0;
    {pc_if_i, pc_id_i, pc_ex_i, branch_target_i, exc_cause_i} = '0;
    {data_load_event_ex_i, exc_save_if_i, exc_save_id_i, exc_save_takenbranch_i,
     exc_restore_i, save_exc_cause_i} = '0;
    {id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i, jump_i, branch_i,
     branch_taken_i, ld_stall_i, jr_stall_i, mem_load_i, mem_store_i} = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errs = n_errors;
    expect_read("reset mstatus", csr_pkg::ADDR_MSTATUS, 32'h6, '1);  // ie 0, mode bits set
    expect_read("reset mepc", csr_pkg::ADDR_MEPC, 32'h0, '1);
    expect_read("reset mcause", csr_pkg::ADDR_MCAUSE, 32'h0, '1);
    expect_read("reset pcer", csr_pkg::ADDR_PCER, 32'h0, '1);
    expect_read("reset pcmr", csr_pkg::ADDR_PCMR, 32'h3, '1);
    expect_read("unmapped", 12'h123, 32'h0, '1);
    expect_signal("reset irq", 2, 32'h0);
    report_test("reset", errs);

    // random ops, model holds the read view of each register
    errs  = n_errors;
    addrs = '{csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE,
              csr_pkg::ADDR_PCER};
    keep  = '{32'h1, 32'hFFFF_FFFF, 32'h8000_001F, 32'h7FF};
    fixed = '{32'h6, 32'h0, 32'h0, 32'h0};
    model = '{32'h6, 32'h0, 32'h0, 32'h0};
    for (int i = 0; i < 20; i++) begin
      r  = $urandom;
      w  = $urandom;
      op = r[3:2];
      model[r[1:0]] = (csr_expect(op, model[r[1:0]], w) & keep[r[1:0]]) | fixed[r[1:0]];
      csr_cycle(op, addrs[r[1:0]], w);
      expect_read($sformatf("op %0d at %h", op, addrs[r[1:0]]), addrs[r[1:0]],
                  model[r[1:0]], '1);
    end
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h0);
    report_test("op rule", errs);

    errs = n_errors;
    csr_cycle(csr_pkg::CSR_OP_SET, csr_pkg::ADDR_MSTATUS, 32'h1);
    wait_irq(1'b1, "ie set");
    for (int k = 0; k < 4; k++) begin
      pc_if_i         = $urandom;
      pc_id_i         = $urandom;
      pc_ex_i         = $urandom;
      branch_target_i = $urandom;
      case (k)
        0:       w = pc_ex_i;  // load event beats the id pc
        1:       w = branch_target_i;
        2:       w = pc_if_i;
        default: w = pc_id_i;
      endcase
      exc_pulse(k);
      wait_irq(1'b0, "save irq off");
      expect_signal($sformatf("save %0d mepc", k), 1, w);
      expect_read("save mestatus", csr_pkg::ADDR_MESTATUS, 32'h7, '1);
      exc_pulse(4);
      wait_irq(1'b1, "restore irq on");
    end
    r                = $urandom;
    exc_cause_i      = r[5:0];
    save_exc_cause_i = 1'b1;
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_MCAUSE, ~r);  // loses to the cause save
    save_exc_cause_i = 1'b0;
    expect_read("mcause", csr_pkg::ADDR_MCAUSE, {r[5], 26'b0, r[4:0]}, '1);
    report_test("exception", errs);

    errs = n_errors;
    count_events("load count", csr_pkg::CNT_LOAD);
    count_events("store count", csr_pkg::CNT_STORE);
    count_events("taken count", csr_pkg::CNT_BRANCH_TAKEN);
    report_test("counting", errs);

    errs = n_errors;
    run_near_top(32'h3);
    expect_read("saturate", counter_addr(0), 32'hFFFF_FFFF, '1);
    run_near_top(32'h1);
    expect_read("wrap below 16", counter_addr(0), 32'h0, 32'hFFFF_FFF0);  // upper bits 0
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCER, 32'h0);
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCMR, 32'h3);
    report_test("saturation", errs);

    errs         = n_errors;
    r            = $urandom;
    core_id_i    = r[3:0];
    cluster_id_i = r[9:4];
    expect_read("mhartid", csr_pkg::ADDR_MHARTID, (32'(r[9:4]) << 5) | 32'(r[3:0]), '1);
    expect_read("mcpuid", csr_pkg::ADDR_MCPUID, 32'h0080_1100, '1);
    expect_read("mimpid", csr_pkg::ADDR_MIMPID, 32'h0000_8000, '1);
    w = $urandom;
    csr_cycle(csr_pkg::CSR_OP_WRITE, csr_pkg::ADDR_PCCR_ALL, w);
    for (int i = 0; i < csr_pkg::N_PERF_COUNTERS; i++) begin
      expect_read($sformatf("all counters %0d", i), counter_addr(i), w, '1);
    end
    report_test("identity", errs);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, whole run is a few microseconds
  initial begin
    #100_000;
    $display("timeout: run did not reach its end");
    $display("Errors found");
    $finish;
  end

endmodule
